//--- include/dual_issue_config.svh
`ifndef DUAL_ISSUE_CONFIG_SVH
`define DUAL_ISSUE_CONFIG_SVH

// Integer datapath and register file geometry
`define XLEN 32
`define REG_COUNT 32

`define CSR_ADDR_WIDTH 12

// Machine and floating-point CSR addresses served by csr_file
`define CSR_FFLAGS 12'h001
`define CSR_FRM 12'h002
`define CSR_FCSR 12'h003
`define CSR_MSTATUS 12'h300
`define CSR_MSCRATCH 12'h340

`endif

//--- hdl/issue_pkg.sv
`include "dual_issue_config.svh"

package issue_pkg;

  typedef struct packed {
    logic rden1;
    logic rden2;
    logic wren;
    logic load;
    logic store;
    logic crden;
    logic cwren;
    logic fwren;
    logic frden1;
    logic frden2;
    logic frden3;
    logic fload;
    logic fstore;
    logic fpu;
    logic fpuc;
    // Set when the FP operation updates fflags
    logic fpuf;
  } operation_t;

  typedef struct packed {
    operation_t op;
    logic [4:0] raddr1;
    logic [4:0] raddr2;
    logic [4:0] raddr3;
    logic [4:0] waddr;
    logic [`CSR_ADDR_WIDTH-1:0] caddr;
    logic [1:0] fmt;
    logic [2:0] rm;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic [`XLEN-1:0] cdata;
  } calculation_t;

  // Snapshot of one downstream stage holding two slots
  typedef struct packed {
    operation_t calc0_op;
    operation_t calc1_op;
    logic [4:0] calc0_waddr;
    logic [4:0] calc1_waddr;
  } pipe_status_t;

  typedef struct packed {
    logic rden1;
    logic rden2;
    logic [4:0] raddr1;
    logic [4:0] raddr2;
  } reg_read_t;

  typedef struct packed {
    logic crden;
    logic [`CSR_ADDR_WIDTH-1:0] craddr;
  } csr_read_t;

  // The fcsr word, read whole or as its rounding mode and flag fields
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [2:0] frm;
      logic [4:0] fflags;
    } fields;
  } fcsr_t;

  localparam operation_t init_operation = '0;
  localparam calculation_t init_calculation = '0;

endpackage

//--- hdl/pair_hazard_unit.sv
`timescale 1ns/1ps

module pair_hazard_unit (
  input  logic                    clock,
  input  logic                    reset,
  input  issue_pkg::calculation_t calc0_in,
  input  issue_pkg::calculation_t calc1_in,
  input  logic                    valid0_in,
  input  logic                    valid1_in,
  input  logic                    hold,
  input  logic                    flush,
  output issue_pkg::calculation_t pair0,
  output issue_pkg::calculation_t pair1,
  output logic                    split,
  output logic                    accept
);
  import issue_pkg::*;

  calculation_t slot0;
  calculation_t slot1;
  calculation_t buf_calc;
  logic buf_valid;
  logic raw_conflict;
  logic mem_conflict;

  always_comb begin
    slot0 = calc0_in;
    slot1 = calc1_in;
    if (!valid0_in) begin
      slot0.op = init_operation;
    end
    if (!valid1_in) begin
      slot1.op = init_operation;
    end
  end

  // A write to x0 creates no dependency
  assign raw_conflict = slot0.op.wren && (slot0.waddr != 5'd0) &&
                        ((slot1.op.rden1 && slot1.raddr1 == slot0.waddr) ||
                         (slot1.op.rden2 && slot1.raddr2 == slot0.waddr));

  assign mem_conflict = (slot0.op.load || slot0.op.store || slot0.op.fload || slot0.op.fstore) &&
                        (slot1.op.load || slot1.op.store || slot1.op.fload || slot1.op.fstore);

  always_comb begin
    if (buf_valid) begin
      pair0 = buf_calc;
      pair1 = init_calculation;
      split = 1'b0;
      accept = 1'b0;
    end else begin
      split = raw_conflict || mem_conflict;
      pair0 = slot0;
      pair1 = split ? init_calculation : slot1;
      accept = !hold && !split;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      buf_valid <= 1'b0;
    end else if (!hold) begin
      buf_valid <= !buf_valid && split;
    end
  end

  always_ff @(posedge clock) begin
    if (!hold && !buf_valid && split) begin
      buf_calc <= slot1;
    end
  end

endmodule

//--- hdl/issue_stage.sv
`timescale 1ns/1ps
`include "dual_issue_config.svh"

module issue_stage (
  input  logic                          clock,
  input  logic                          reset,
  input  issue_pkg::calculation_t       pair0,
  input  issue_pkg::calculation_t       pair1,
  input  logic                          split,
  input  issue_pkg::pipe_status_t       ex_status,
  input  issue_pkg::pipe_status_t       mem_status,
  input  logic                          downstream_stall,
  input  logic                          flush,
  input  logic [1:0]                    fs,
  input  logic [2:0]                    frm,
  input  logic [3:0][`XLEN-1:0]         rdata,
  input  logic [`XLEN-1:0]              csr_rdata,
  output issue_pkg::reg_read_t          reg_read0,
  output issue_pkg::reg_read_t          reg_read1,
  output issue_pkg::csr_read_t          csr_read,
  output logic                          hold,
  output issue_pkg::calculation_t       issued0,
  output issue_pkg::calculation_t       issued1,
  output logic                          halt,
  output logic                          stall
);
  import issue_pkg::*;

  calculation_t gated0;
  calculation_t gated1;
  calculation_t next0;
  calculation_t next1;
  logic csr_busy;
  logic fpuf_busy;
  logic load_stall;
  logic interlock;

  // FP instructions are illegal while FS is off; dynamic rounding reads frm
  function automatic calculation_t gate_fp(input calculation_t c, input logic [1:0] fs_in,
                                           input logic [2:0] frm_in);
    calculation_t g;
    g = c;
    if (fs_in == 2'b00) begin
      g.op.fwren = 1'b0;
      g.op.frden1 = 1'b0;
      g.op.frden2 = 1'b0;
      g.op.frden3 = 1'b0;
      g.op.fload = 1'b0;
      g.op.fstore = 1'b0;
      g.op.fpu = 1'b0;
      g.op.fpuc = 1'b0;
      g.op.fpuf = 1'b0;
      g.fmt = 2'b00;
      g.rm = 3'b000;
    end else if (g.rm == 3'b111) begin
      g.rm = frm_in;
    end
    return g;
  endfunction

  function automatic logic load_hit(input operation_t e_op, input logic [4:0] e_waddr,
                                    input calculation_t c);
    logic int_hit;
    logic fp_hit;
    int_hit = (c.op.rden1 && c.raddr1 == e_waddr) || (c.op.rden2 && c.raddr2 == e_waddr);
    fp_hit = (c.op.frden1 && c.raddr1 == e_waddr) || (c.op.frden2 && c.raddr2 == e_waddr) ||
             (c.op.frden3 && c.raddr3 == e_waddr);
    return (e_op.load && int_hit) || (e_op.fload && fp_hit);
  endfunction

  function automatic logic flag_read(input calculation_t c);
    return c.op.crden && (c.caddr == `CSR_FFLAGS || c.caddr == `CSR_FCSR);
  endfunction

  assign gated0 = gate_fp(pair0, fs, frm);
  assign gated1 = gate_fp(pair1, fs, frm);

  assign reg_read0 = '{rden1: gated0.op.rden1, rden2: gated0.op.rden2,
                       raddr1: gated0.raddr1, raddr2: gated0.raddr2};
  assign reg_read1 = '{rden1: gated1.op.rden1, rden2: gated1.op.rden2,
                       raddr1: gated1.raddr1, raddr2: gated1.raddr2};

  // Slot 0 has priority on the single CSR read port
  assign csr_read.crden = gated0.op.crden || gated1.op.crden;
  assign csr_read.craddr = gated0.op.crden ? gated0.caddr : gated1.caddr;

  assign csr_busy = ex_status.calc0_op.cwren || ex_status.calc1_op.cwren ||
                    mem_status.calc0_op.cwren || mem_status.calc1_op.cwren;
  assign fpuf_busy = ex_status.calc0_op.fpuf || ex_status.calc1_op.fpuf ||
                     mem_status.calc0_op.fpuf || mem_status.calc1_op.fpuf;

  assign load_stall = load_hit(ex_status.calc0_op, ex_status.calc0_waddr, gated0) ||
                      load_hit(ex_status.calc1_op, ex_status.calc1_waddr, gated0) ||
                      load_hit(ex_status.calc0_op, ex_status.calc0_waddr, gated1) ||
                      load_hit(ex_status.calc1_op, ex_status.calc1_waddr, gated1);

  assign interlock = (csr_read.crden && csr_busy) ||
                     ((flag_read(gated0) || flag_read(gated1)) && fpuf_busy) ||
                     load_stall;

  assign hold = interlock || downstream_stall;

  always_comb begin
    next0 = gated0;
    next1 = gated1;
    next0.rdata1 = rdata[0];
    next0.rdata2 = rdata[1];
    next1.rdata1 = rdata[2];
    next1.rdata2 = rdata[3];
    next0.cdata = gated0.op.crden ? csr_rdata : '0;
    next1.cdata = gated1.op.crden ? csr_rdata : '0;
    // Insert a bubble while the pair waits upstream
    if (hold) begin
      next0.op = init_operation;
      next1.op = init_operation;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      issued0 <= init_calculation;
      issued1 <= init_calculation;
      halt <= 1'b0;
      stall <= 1'b0;
    end else begin
      issued0 <= next0;
      issued1 <= next1;
      halt <= split && !hold;
      stall <= interlock;
    end
  end

endmodule

//--- hdl/register_file.sv
`timescale 1ns/1ps
`include "dual_issue_config.svh"

module register_file (
  input  logic                  clock,
  input  logic                  reset,
  input  issue_pkg::reg_read_t  reg_read0,
  input  issue_pkg::reg_read_t  reg_read1,
  input  logic                  reg_wren,
  input  logic [4:0]            reg_waddr,
  input  logic [`XLEN-1:0]      reg_wdata,
  output logic [3:0][`XLEN-1:0] rdata
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  // Writes are ignored while the core sits in reset
  always_ff @(posedge clock) begin
    if (reset && reg_wren && reg_waddr != 5'd0) begin
      regs[reg_waddr] <= reg_wdata;
    end
  end

  // x0 is hardwired, so its entry is never read
  always_comb begin
    rdata[0] = (reg_read0.rden1 && reg_read0.raddr1 != 5'd0) ? regs[reg_read0.raddr1] : '0;
    rdata[1] = (reg_read0.rden2 && reg_read0.raddr2 != 5'd0) ? regs[reg_read0.raddr2] : '0;
    rdata[2] = (reg_read1.rden1 && reg_read1.raddr1 != 5'd0) ? regs[reg_read1.raddr1] : '0;
    rdata[3] = (reg_read1.rden2 && reg_read1.raddr2 != 5'd0) ? regs[reg_read1.raddr2] : '0;
  end

endmodule

//--- hdl/csr_file.sv
`timescale 1ns/1ps
`include "dual_issue_config.svh"

module csr_file (
  input  logic                       clock,
  input  logic                       reset,
  input  issue_pkg::csr_read_t       csr_read,
  input  logic                       csr_wren,
  input  logic [`CSR_ADDR_WIDTH-1:0] csr_waddr,
  input  logic [`XLEN-1:0]           csr_wdata,
  output logic [`XLEN-1:0]           csr_rdata,
  output logic [1:0]                 fs,
  output logic [2:0]                 frm
);
  import issue_pkg::*;

  fcsr_t fcsr;
  logic [`XLEN-1:0] mscratch;

  always_ff @(posedge clock) begin
    if (!reset) begin
      fs <= 2'b00;
      fcsr <= '0;
    end else if (csr_wren) begin
      case (csr_waddr)
        `CSR_MSTATUS: fs <= csr_wdata[14:13];
        `CSR_FFLAGS: fcsr.fields.fflags <= csr_wdata[4:0];
        `CSR_FRM: fcsr.fields.frm <= csr_wdata[2:0];
        `CSR_FCSR: fcsr.raw <= csr_wdata[7:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (csr_wren && csr_waddr == `CSR_MSCRATCH) begin
      mscratch <= csr_wdata;
    end
  end

  always_comb begin
    csr_rdata = '0;
    if (csr_read.crden) begin
      case (csr_read.craddr)
        // Only FS is implemented in mstatus
        `CSR_MSTATUS: csr_rdata[14:13] = fs;
        `CSR_FFLAGS: csr_rdata[4:0] = fcsr.fields.fflags;
        `CSR_FRM: csr_rdata[2:0] = fcsr.fields.frm;
        `CSR_FCSR: csr_rdata[7:0] = fcsr.raw;
        `CSR_MSCRATCH: csr_rdata = mscratch;
        default: csr_rdata = '0;
      endcase
    end
  end

  assign frm = fcsr.fields.frm;

endmodule

//--- hdl/issue_top.sv
`timescale 1ns/1ps
`include "dual_issue_config.svh"

module issue_top (
  input  logic                       clock,
  input  logic                       reset,
  input  issue_pkg::calculation_t    calc0_in,
  input  issue_pkg::calculation_t    calc1_in,
  input  logic                       valid0_in,
  input  logic                       valid1_in,
  input  issue_pkg::pipe_status_t    ex_status,
  input  issue_pkg::pipe_status_t    mem_status,
  input  logic                       downstream_stall,
  input  logic                       flush,
  input  logic                       reg_wren,
  input  logic [4:0]                 reg_waddr,
  input  logic [`XLEN-1:0]           reg_wdata,
  input  logic                       csr_wren,
  input  logic [`CSR_ADDR_WIDTH-1:0] csr_waddr,
  input  logic [`XLEN-1:0]           csr_wdata,
  output issue_pkg::calculation_t    issued0,
  output issue_pkg::calculation_t    issued1,
  output logic                       halt,
  output logic                       stall,
  output logic                       accept
);
  import issue_pkg::*;

  calculation_t pair0;
  calculation_t pair1;
  logic split;
  logic hold;
  reg_read_t reg_read0;
  reg_read_t reg_read1;
  csr_read_t csr_read;
  logic [3:0][`XLEN-1:0] rdata;
  logic [`XLEN-1:0] csr_rdata;
  logic [1:0] fs;
  logic [2:0] frm;

  pair_hazard_unit u_pair_hazard_unit (
    .clock     (clock),
    .reset     (reset),
    .calc0_in  (calc0_in),
    .calc1_in  (calc1_in),
    .valid0_in (valid0_in),
    .valid1_in (valid1_in),
    .hold      (hold),
    .flush     (flush),
    .pair0     (pair0),
    .pair1     (pair1),
    .split     (split),
    .accept    (accept)
  );

  issue_stage u_issue_stage (
    .clock            (clock),
    .reset            (reset),
    .pair0            (pair0),
    .pair1            (pair1),
    .split            (split),
    .ex_status        (ex_status),
    .mem_status       (mem_status),
    .downstream_stall (downstream_stall),
    .flush            (flush),
    .fs               (fs),
    .frm              (frm),
    .rdata            (rdata),
    .csr_rdata        (csr_rdata),
    .reg_read0        (reg_read0),
    .reg_read1        (reg_read1),
    .csr_read         (csr_read),
    .hold             (hold),
    .issued0          (issued0),
    .issued1          (issued1),
    .halt             (halt),
    .stall            (stall)
  );

  register_file u_register_file (
    .clock     (clock),
    .reset     (reset),
    .reg_read0 (reg_read0),
    .reg_read1 (reg_read1),
    .reg_wren  (reg_wren),
    .reg_waddr (reg_waddr),
    .reg_wdata (reg_wdata),
    .rdata     (rdata)
  );

  csr_file u_csr_file (
    .clock     (clock),
    .reset     (reset),
    .csr_read  (csr_read),
    .csr_wren  (csr_wren),
    .csr_waddr (csr_waddr),
    .csr_wdata (csr_wdata),
    .csr_rdata (csr_rdata),
    .fs        (fs),
    .frm       (frm)
  );

endmodule

//--- verification/issue_assertions.sv
`timescale 1ns/1ps

module issue_assertions (
  input logic                    clock,
  input logic                    reset,
  input logic                    hold,
  input logic                    split,
  input logic                    flush,
  input logic                    halt,
  input logic                    stall,
  input issue_pkg::calculation_t issued0,
  input issue_pkg::calculation_t issued1
);

  property flush_clears_stall;
    @(posedge clock) disable iff (!reset) flush |=> !stall;
  endproperty

  // A held cycle leaves a bubble in both issue slots
  property hold_gives_bubble;
    @(posedge clock) disable iff (!reset) hold |=> (issued0.op == '0) && (issued1.op == '0);
  endproperty

  property halt_follows_split;
    @(posedge clock) disable iff (!reset) halt |-> $past(split);
  endproperty

  assert property (flush_clears_stall) else $error("stall set in the cycle after a flush");
  assert property (hold_gives_bubble) else $error("issued ops not cleared after hold");
  assert property (halt_follows_split) else $error("halt set without a split");

endmodule

bind issue_stage issue_assertions u_issue_assertions (
  .clock   (clock),
  .reset   (reset),
  .hold    (hold),
  .split   (split),
  .flush   (flush),
  .halt    (halt),
  .stall   (stall),
  .issued0 (issued0),
  .issued1 (issued1)
);

//--- verification/issue_tb.sv
`timescale 1ns/1ps
`include "dual_issue_config.svh"

module issue_tb;
  import issue_pkg::*;

  localparam int CHECK_W = $bits(calculation_t);
  localparam int LOAD0 = 1;
  localparam int CSRW0 = 2;
  localparam int CSRW1 = 3;
  localparam int FLAGS0 = 4;
  localparam logic [2:0] FRM_VALUE = 3'd2;
  localparam pipe_status_t QUIET = '0;
  localparam calculation_t NOP = '0;

  // Stimulus first, then the issue register expected one edge later
  typedef struct packed {
    calculation_t c0;
    calculation_t c1;
    pipe_status_t ex;
    pipe_status_t mem;
    logic dstall;
    logic flush;
    logic [1:0] fs;
    calculation_t e0;
    calculation_t e1;
    logic exp_zero;
    logic exp_halt;
    logic exp_stall;
    logic exp_accept;
  } row_t;

  logic clock = 1'b0;
  logic reset;
  calculation_t calc0_in;
  calculation_t calc1_in;
  logic valid0_in;
  logic valid1_in;
  pipe_status_t ex_status;
  pipe_status_t mem_status;
  logic downstream_stall;
  logic flush;
  logic reg_wren;
  logic [4:0] reg_waddr;
  logic [`XLEN-1:0] reg_wdata;
  logic csr_wren;
  logic [`CSR_ADDR_WIDTH-1:0] csr_waddr;
  logic [`XLEN-1:0] csr_wdata;
  calculation_t issued0;
  calculation_t issued1;
  logic halt;
  logic stall;
  logic accept;

  row_t rows[$];
  string names[$];
  int row_start[$];
  int row_count = 0;
  int checks = 0;
  int errors = 0;
  integer seed = 32'h17b6db1e;
  logic [`XLEN-1:0] reg_model [`REG_COUNT];
  logic [`XLEN-1:0] mscratch_model;
  fcsr_t fcsr_model;
  logic [1:0] fs_model;

  issue_top dut (
    .clock            (clock),
    .reset            (reset),
    .calc0_in         (calc0_in),
    .calc1_in         (calc1_in),
    .valid0_in        (valid0_in),
    .valid1_in        (valid1_in),
    .ex_status        (ex_status),
    .mem_status       (mem_status),
    .downstream_stall (downstream_stall),
    .flush            (flush),
    .reg_wren         (reg_wren),
    .reg_waddr        (reg_waddr),
    .reg_wdata        (reg_wdata),
    .csr_wren         (csr_wren),
    .csr_waddr        (csr_waddr),
    .csr_wdata        (csr_wdata),
    .issued0          (issued0),
    .issued1          (issued1),
    .halt             (halt),
    .stall            (stall),
    .accept           (accept)
  );

  always #2 clock = ~clock;

  function automatic calculation_t alu_op(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    calculation_t c;
    c = '0;
    c.op.rden1 = 1'b1;
    c.op.rden2 = 1'b1;
    c.op.wren = 1'b1;
    c.waddr = rd;
    c.raddr1 = rs1;
    c.raddr2 = rs2;
    return c;
  endfunction

  function automatic calculation_t load_op(input logic [4:0] rd, input logic [4:0] rs1);
    calculation_t c;
    c = '0;
    c.op.rden1 = 1'b1;
    c.op.wren = 1'b1;
    c.op.load = 1'b1;
    c.waddr = rd;
    c.raddr1 = rs1;
    return c;
  endfunction

  function automatic calculation_t store_op(input logic [4:0] rs1, input logic [4:0] rs2);
    calculation_t c;
    c = '0;
    c.op.rden1 = 1'b1;
    c.op.rden2 = 1'b1;
    c.op.store = 1'b1;
    c.raddr1 = rs1;
    c.raddr2 = rs2;
    return c;
  endfunction

  function automatic calculation_t csr_read_op(input logic [4:0] rd,
                                               input logic [`CSR_ADDR_WIDTH-1:0] addr);
    calculation_t c;
    c = '0;
    c.op.crden = 1'b1;
    c.op.wren = 1'b1;
    c.waddr = rd;
    c.caddr = addr;
    return c;
  endfunction

  // FP to integer conversion that sets fflags and writes an integer register
  function automatic calculation_t fp_convert_op(input logic [4:0] rd, input logic [4:0] fs1,
                                                 input logic [2:0] rm, input logic [1:0] fmt);
    calculation_t c;
    c = '0;
    c.op.wren = 1'b1;
    c.op.frden1 = 1'b1;
    c.op.fpu = 1'b1;
    c.op.fpuf = 1'b1;
    c.waddr = rd;
    c.raddr1 = fs1;
    c.rm = rm;
    c.fmt = fmt;
    return c;
  endfunction

  // What is left of a conversion once the FP bits are stripped
  function automatic calculation_t int_write_op(input logic [4:0] rd, input logic [4:0] rs1);
    calculation_t c;
    c = '0;
    c.op.wren = 1'b1;
    c.waddr = rd;
    c.raddr1 = rs1;
    return c;
  endfunction

  function automatic pipe_status_t busy_status(input int kind, input logic [4:0] w);
    pipe_status_t s;
    s = '0;
    case (kind)
      LOAD0: begin
        s.calc0_op.load = 1'b1;
        s.calc0_waddr = w;
      end
      CSRW0: s.calc0_op.cwren = 1'b1;
      CSRW1: s.calc1_op.cwren = 1'b1;
      FLAGS0: s.calc0_op.fpuf = 1'b1;
      default: ;
    endcase
    return s;
  endfunction

  function automatic logic [`XLEN-1:0] csr_value(input logic [`CSR_ADDR_WIDTH-1:0] addr);
    case (addr)
      `CSR_FFLAGS: return {27'b0, fcsr_model.fields.fflags};
      `CSR_FRM: return {29'b0, fcsr_model.fields.frm};
      `CSR_FCSR: return {24'b0, fcsr_model.raw};
      `CSR_MSTATUS: return {17'b0, fs_model, 13'b0};
      `CSR_MSCRATCH: return mscratch_model;
      default: return '0;
    endcase
  endfunction

  function automatic calculation_t with_data(input calculation_t e);
    calculation_t d;
    d = e;
    if (e.op.rden1 && e.raddr1 != 5'd0) begin
      d.rdata1 = reg_model[e.raddr1];
    end
    if (e.op.rden2 && e.raddr2 != 5'd0) begin
      d.rdata2 = reg_model[e.raddr2];
    end
    if (e.op.crden) begin
      d.cdata = csr_value(e.caddr);
    end
    return d;
  endfunction

  task automatic check_value(input string name, input logic [CHECK_W-1:0] got,
                             input logic [CHECK_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic add_row(input string name, input calculation_t c0, input calculation_t c1,
                         input pipe_status_t ex, input pipe_status_t mem, input logic [3:0] ctrl,
                         input calculation_t e0, input calculation_t e1, input logic [3:0] expf);
    row_t r;
    r.c0 = c0;
    r.c1 = c1;
    r.ex = ex;
    r.mem = mem;
    {r.dstall, r.flush, r.fs} = ctrl;
    r.e0 = e0;
    r.e1 = e1;
    {r.exp_zero, r.exp_halt, r.exp_stall, r.exp_accept} = expf;
    rows.push_back(r);
    names.push_back(name);
  endtask

  // ctrl is {downstream stall, flush, fs} and expf is {all zero, halt, stall, accept}
  task automatic build_table();
    add_row("pair without conflict", alu_op(5, 1, 2), alu_op(6, 3, 0), QUIET, QUIET, 4'b0001,
            alu_op(5, 1, 2), alu_op(6, 3, 0), 4'b0001);
    add_row("raw pair splits", alu_op(7, 1, 2), alu_op(8, 7, 3), QUIET, QUIET, 4'b0001,
            alu_op(7, 1, 2), NOP, 4'b0100);
    add_row("split slot 1 alone", NOP, NOP, QUIET, QUIET, 4'b0001,
            alu_op(8, 7, 3), NOP, 4'b0000);
    add_row("memory pair splits", load_op(9, 1), store_op(2, 3), QUIET, QUIET, 4'b0001,
            load_op(9, 1), NOP, 4'b0100);
    add_row("split store alone", NOP, NOP, QUIET, QUIET, 4'b0001,
            store_op(2, 3), NOP, 4'b0000);
    add_row("load-use bubble", alu_op(10, 4, 1), alu_op(11, 2, 3), busy_status(LOAD0, 4),
            QUIET, 4'b0001, NOP, NOP, 4'b0010);
    add_row("held pair issues", alu_op(10, 4, 1), alu_op(11, 2, 3), QUIET, QUIET, 4'b0001,
            alu_op(10, 4, 1), alu_op(11, 2, 3), 4'b0001);
    add_row("csr write in execute", csr_read_op(12, `CSR_MSCRATCH), alu_op(13, 1, 1),
            busy_status(CSRW1, 0), QUIET, 4'b0001, NOP, NOP, 4'b0010);
    add_row("csr write in memory", csr_read_op(12, `CSR_MSCRATCH), alu_op(13, 1, 1),
            QUIET, busy_status(CSRW0, 0), 4'b0001, NOP, NOP, 4'b0010);
    add_row("csr read issues", csr_read_op(12, `CSR_MSCRATCH), alu_op(13, 1, 1), QUIET, QUIET,
            4'b0001, csr_read_op(12, `CSR_MSCRATCH), alu_op(13, 1, 1), 4'b0001);
    add_row("fflags read vs fpuf", csr_read_op(14, `CSR_FFLAGS), alu_op(15, 2, 2),
            busy_status(FLAGS0, 0), QUIET, 4'b0001, NOP, NOP, 4'b0010);
    add_row("mscratch read vs fpuf", csr_read_op(14, `CSR_MSCRATCH), alu_op(15, 2, 2),
            busy_status(FLAGS0, 0), QUIET, 4'b0001,
            csr_read_op(14, `CSR_MSCRATCH), alu_op(15, 2, 2), 4'b0001);
    add_row("fcsr read", alu_op(15, 2, 2), csr_read_op(14, `CSR_FCSR), QUIET, QUIET, 4'b0001,
            alu_op(15, 2, 2), csr_read_op(14, `CSR_FCSR), 4'b0001);
    add_row("dynamic rounding", fp_convert_op(16, 1, 7, 1), fp_convert_op(17, 2, 3, 0),
            QUIET, QUIET, 4'b0001, fp_convert_op(16, 1, FRM_VALUE, 1),
            fp_convert_op(17, 2, 3, 0), 4'b0001);
    add_row("fs off strips fp", fp_convert_op(16, 1, 7, 1), alu_op(18, 1, 2), QUIET, QUIET,
            4'b0000, int_write_op(16, 1), alu_op(18, 1, 2), 4'b0001);
    add_row("flush during stall", alu_op(19, 4, 1), NOP, busy_status(LOAD0, 4), QUIET,
            4'b0101, NOP, NOP, 4'b1000);
    add_row("flush during split", alu_op(20, 1, 2), alu_op(21, 20, 3), QUIET, QUIET, 4'b0101,
            NOP, NOP, 4'b1000);
    add_row("fresh pair after flush", alu_op(22, 5, 6), alu_op(23, 7, 8), QUIET, QUIET,
            4'b0001, alu_op(22, 5, 6), alu_op(23, 7, 8), 4'b0001);
    add_row("downstream stall", alu_op(24, 1, 2), alu_op(25, 3, 4), QUIET, QUIET, 4'b1001,
            NOP, NOP, 4'b0000);
    add_row("after downstream stall", alu_op(24, 1, 2), alu_op(25, 3, 4), QUIET, QUIET,
            4'b0001, alu_op(24, 1, 2), alu_op(25, 3, 4), 4'b0001);
  endtask

  task automatic idle_inputs();
    calc0_in <= '0;
    calc1_in <= '0;
    valid0_in <= 1'b0;
    valid1_in <= 1'b0;
    ex_status <= '0;
    mem_status <= '0;
    downstream_stall <= 1'b0;
    flush <= 1'b0;
    reg_wren <= 1'b0;
    csr_wren <= 1'b0;
  endtask

  task automatic drive_row(input row_t r);
    calc0_in <= r.c0;
    calc1_in <= r.c1;
    valid0_in <= (r.c0.op != '0);
    valid1_in <= (r.c1.op != '0);
    ex_status <= r.ex;
    mem_status <= r.mem;
    downstream_stall <= r.dstall;
    flush <= r.flush;
    reg_wren <= 1'b0;
    csr_wren <= 1'b0;
  endtask

  task automatic write_csr(input logic [`CSR_ADDR_WIDTH-1:0] addr, input logic [`XLEN-1:0] data);
    @(posedge clock);
    idle_inputs();
    csr_wren <= 1'b1;
    csr_waddr <= addr;
    csr_wdata <= data;
  endtask

  task automatic preload();
    for (int i = 1; i < `REG_COUNT; i++) begin
      @(posedge clock);
      reg_model[i] = $random(seed);
      reg_wren <= 1'b1;
      reg_waddr <= 5'(i);
      reg_wdata <= reg_model[i];
    end
    fcsr_model = '0;
    mscratch_model = $random(seed);
    write_csr(`CSR_MSTATUS, {17'b0, 2'b01, 13'b0});
    fs_model = 2'b01;
    write_csr(`CSR_FRM, {29'b0, FRM_VALUE});
    fcsr_model.fields.frm = FRM_VALUE;
    write_csr(`CSR_FFLAGS, 32'h13);
    fcsr_model.fields.fflags = 5'h13;
    write_csr(`CSR_MSCRATCH, mscratch_model);
  endtask

  task automatic finish_row(input int i);
    if (rows[i].exp_zero) begin
      check_value("issued0", issued0, '0);
      check_value("issued1", issued1, '0);
    end else begin
      if (rows[i].e0.op == '0) begin
        check_value("issued0.op", CHECK_W'(issued0.op), '0);
      end else begin
        check_value("issued0", issued0, with_data(rows[i].e0));
      end
      if (rows[i].e1.op == '0) begin
        check_value("issued1.op", CHECK_W'(issued1.op), '0);
      end else begin
        check_value("issued1", issued1, with_data(rows[i].e1));
      end
    end
    check_value("halt", CHECK_W'(halt), CHECK_W'(rows[i].exp_halt));
    check_value("stall", CHECK_W'(stall), CHECK_W'(rows[i].exp_stall));
    $display("Row %0d (%s): %s", i, names[i], (errors == row_start[i]) ? "ok" : "mismatch");
  endtask

  initial begin
    int prev;
    reset = 1'b0;
    calc0_in = '0;
    calc1_in = '0;
    valid0_in = 1'b0;
    valid1_in = 1'b0;
    ex_status = '0;
    mem_status = '0;
    downstream_stall = 1'b0;
    flush = 1'b0;
    reg_wren = 1'b0;
    reg_waddr = '0;
    reg_wdata = '0;
    csr_wren = 1'b0;
    csr_waddr = '0;
    csr_wdata = '0;
    build_table();
    row_count = rows.size();
    repeat (16) @(posedge clock);
    reset <= 1'b1;
    preload();
    // Each row's issue register is checked half a cycle after the next row is driven
    prev = -1;
    for (int i = 0; i < rows.size(); i++) begin
      if (rows[i].fs != fs_model) begin
        write_csr(`CSR_MSTATUS, {17'b0, rows[i].fs, 13'b0});
        fs_model = rows[i].fs;
        @(negedge clock);
        if (prev >= 0) begin
          finish_row(prev);
        end
        prev = -1;
      end
      @(posedge clock);
      drive_row(rows[i]);
      @(negedge clock);
      if (prev >= 0) begin
        finish_row(prev);
      end
      row_start.push_back(errors);
      check_value("accept", CHECK_W'(accept), CHECK_W'(rows[i].exp_accept));
      prev = i;
    end
    @(posedge clock);
    idle_inputs();
    @(negedge clock);
    finish_row(prev);
    $display("Summary: %0d rows, %0d checks, %0d errors", row_count, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    int limit;
    wait (row_count > 0);
    limit = (row_count + `REG_COUNT + 16) * 10;
    repeat (limit) @(posedge clock);
    $display("Timeout: the table did not finish within %0d cycles", limit);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- dual_issue.f
+incdir+include
hdl/issue_pkg.sv
hdl/pair_hazard_unit.sv
hdl/issue_stage.sv
hdl/register_file.sv
hdl/csr_file.sv
hdl/issue_top.sv
verification/issue_assertions.sv
verification/issue_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module issue_tb -f dual_issue.f -o issue_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/issue_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Verification failed" "$log"; then
  exit 1
fi
exit 0
